// ==== src/ex_types_pkg.sv ====
package ex_types_pkg;

  // integer datapath
  localparam int data_w = 32;

  // packed multimedia datapath
  localparam int mm_w = 64;
  localparam int lane_w = 16;
  localparam int mm_lanes = mm_w / lane_w;

  // eight general purpose registers
  localparam int reg_idx_w = 3;

  // one integer data word
  typedef logic [data_w-1:0] word_t;

  // full mmx register value
  typedef logic [mm_w-1:0] mm_t;

  // one 16-bit lane of an mmx value
  typedef logic [lane_w-1:0] lane_t;

  // register file index
  typedef logic [reg_idx_w-1:0] reg_idx_t;

  // eflags image of which only the arithmetic bits are produced here
  typedef logic [data_w-1:0] flags_t;

  // ecx style repeat count
  typedef logic [data_w-1:0] count_t;

endpackage

// ==== src/ex_ctrl_pkg.sv ====
package ex_ctrl_pkg;

  // alu operation code
  typedef enum logic [2:0] {
    op_add    = 3'd0,
    op_sub    = 3'd1,
    op_and    = 3'd2,
    op_or     = 3'd3,
    op_xor    = 3'd4,
    op_pass_b = 3'd5,
    op_shl    = 3'd6,
    op_shr    = 3'd7
  } alu_op_e;

  // operand size
  typedef enum logic [1:0] {
    size_byte  = 2'd0,
    size_word  = 2'd1,
    size_dword = 2'd2
  } datasize_e;

  // eflags bit positions
  localparam int flag_cf = 0;
  localparam int flag_zf = 6;
  localparam int flag_sf = 7;
  localparam int flag_df = 10;
  localparam int flag_of = 11;

  // decoded micro-op with operands
  typedef struct packed {
    alu_op_e                  op;
    datasize_e                size;
    logic                     ld_gpr1;
    logic                     ld_gpr2;
    logic                     ld_mm;
    logic                     dcache_write;
    logic                     is_cmpxchg;
    logic                     is_cmps_first;
    logic                     is_cmps_second;
    logic                     repne;
    logic                     sp_pop;
    logic                     jmp_stall;
    logic                     ld_flags;
    ex_types_pkg::reg_idx_t   dr1;
    ex_types_pkg::reg_idx_t   dr2;
    ex_types_pkg::word_t      a;
    ex_types_pkg::word_t      b;
    ex_types_pkg::word_t      c;
    ex_types_pkg::mm_t        mm_a;
    ex_types_pkg::mm_t        mm_b;
    ex_types_pkg::word_t      address;
    ex_types_pkg::word_t      neip;
  } ex_uop_t;

  // everything writeback needs for one micro-op
  typedef struct packed {
    ex_types_pkg::word_t      result_a;
    ex_types_pkg::word_t      result_b;
    ex_types_pkg::word_t      result_c;
    ex_types_pkg::mm_t        result_mm;
    ex_types_pkg::flags_t     flags;
    ex_types_pkg::reg_idx_t   dr1;
    ex_types_pkg::reg_idx_t   dr2;
    ex_types_pkg::word_t      address;
    logic                     ld_gpr1;
    logic                     ld_gpr2;
    logic                     ld_mm;
    logic                     dcache_write;
    logic                     repne_done;
    ex_types_pkg::word_t      neip;
  } wb_bundle_t;

  // destinations being loaded, for decode dependency checks
  typedef struct packed {
    logic gpr1;
    logic gpr2;
    logic mm;
    logic dcache_write;
  } dep_t;

  // raw functional unit outputs before result selection
  typedef struct packed {
    ex_types_pkg::word_t      alu;
    ex_types_pkg::flags_t     alu_flags;
    ex_types_pkg::word_t      shift;
    ex_types_pkg::flags_t     shift_flags;
    ex_types_pkg::mm_t        mm;
    ex_types_pkg::count_t     count_minus_one;
    ex_types_pkg::word_t      sp_pop;
    ex_types_pkg::word_t      cmps_ptr;
  } fu_raw_t;

endpackage

// ==== src/operand_select_ex.sv ====
`timescale 1ns/10ps

module operand_select_ex (
  input  logic                   clk,
  input  logic                   reset,
  input  ex_ctrl_pkg::ex_uop_t   uop,
  input  ex_types_pkg::count_t   count_fwd,
  input  logic                   accept,
  output ex_types_pkg::word_t    operand_b,
  output ex_types_pkg::count_t   count
);

  logic                  repne_active;
  ex_types_pkg::count_t  count_reg;
  ex_types_pkg::count_t  count_next;

  // every uop takes its second operand from b
  assign operand_b = uop.b;

  // steady state repne takes the locally decremented count
  always_comb begin
    if (uop.repne && repne_active) begin
      count = count_reg;
    end else if (uop.repne) begin
      count = uop.c;
    end else begin
      count = count_fwd;
    end
  end

  assign count_next = (count == '0) ? '0 : count - 32'd1;

  always_ff @(posedge clk) begin
    if (reset) begin
      repne_active <= 1'b0;
      count_reg    <= '0;
    end else if (accept) begin
      if (uop.repne) begin
        // loop stays live while another iteration remains
        repne_active <= (count > 32'd1);
        count_reg    <= count_next;
      end else begin
        repne_active <= 1'b0;
        count_reg    <= '0;
      end
    end
  end

  // a steady state repne step never starts from an empty count
  a_repne_count_nonzero: assert property (
    @(posedge clk) disable iff (reset)
    (accept && uop.repne && repne_active) |-> (count_reg != '0)
  );

endmodule

// ==== src/functional_unit_ex.sv ====
`timescale 1ns/10ps

module functional_unit_ex (
  input  ex_ctrl_pkg::ex_uop_t   uop,
  input  ex_types_pkg::word_t    operand_b,
  input  ex_types_pkg::count_t   count,
  input  ex_types_pkg::flags_t   flags_fwd,
  output ex_ctrl_pkg::fu_raw_t   raw
);

  ex_types_pkg::word_t                  mask;
  ex_types_pkg::word_t                  step;
  logic [4:0]                           msb;
  ex_types_pkg::word_t                  alu_a;
  ex_types_pkg::word_t                  alu_b;
  logic [ex_types_pkg::data_w:0]        sum;
  logic [ex_types_pkg::data_w:0]        diff;
  ex_types_pkg::word_t                  alu_res;
  logic                                 alu_cf;
  logic                                 alu_of;
  ex_types_pkg::flags_t                 alu_flags;
  logic [4:0]                           shamt;
  logic [2*ex_types_pkg::data_w-1:0]    shl_wide;
  logic [2*ex_types_pkg::data_w-1:0]    shr_wide;
  ex_types_pkg::word_t                  shift_res;
  ex_types_pkg::flags_t                 shift_flags;
  ex_types_pkg::mm_t                    mm_sum;

  // size decode
  always_comb begin
    case (uop.size)
      ex_ctrl_pkg::size_byte: begin
        mask = 32'h0000_00ff;
        msb  = 5'd7;
        step = 32'd1;
      end
      ex_ctrl_pkg::size_word: begin
        mask = 32'h0000_ffff;
        msb  = 5'd15;
        step = 32'd2;
      end
      default: begin
        mask = 32'hffff_ffff;
        msb  = 5'd31;
        step = 32'd4;
      end
    endcase
  end

  // cmpxchg compares a against the accumulator in c
  assign alu_a = uop.a & mask;
  assign alu_b = (uop.is_cmpxchg ? uop.c : operand_b) & mask;
  assign sum   = {1'b0, alu_a} + {1'b0, alu_b};
  assign diff  = {1'b0, alu_a} - {1'b0, alu_b};

  always_comb begin
    alu_cf = 1'b0;
    alu_of = 1'b0;
    if (uop.is_cmpxchg || uop.op == ex_ctrl_pkg::op_sub) begin
      alu_res = diff[ex_types_pkg::data_w-1:0] & mask;
      alu_cf  = diff[{1'b0, msb} + 6'd1];
      alu_of  = (alu_a[msb] != alu_b[msb]) && (alu_res[msb] != alu_a[msb]);
    end else begin
      case (uop.op)
        ex_ctrl_pkg::op_add: begin
          alu_res = sum[ex_types_pkg::data_w-1:0] & mask;
          alu_cf  = sum[{1'b0, msb} + 6'd1];
          alu_of  = (alu_a[msb] == alu_b[msb]) && (alu_res[msb] != alu_a[msb]);
        end
        ex_ctrl_pkg::op_and: alu_res = alu_a & alu_b;
        ex_ctrl_pkg::op_or:  alu_res = alu_a | alu_b;
        ex_ctrl_pkg::op_xor: alu_res = alu_a ^ alu_b;
        default:             alu_res = alu_b;
      endcase
    end
    alu_flags                       = flags_fwd;
    alu_flags[ex_ctrl_pkg::flag_cf] = alu_cf;
    alu_flags[ex_ctrl_pkg::flag_zf] = (alu_res == '0);
    alu_flags[ex_ctrl_pkg::flag_sf] = alu_res[msb];
    alu_flags[ex_ctrl_pkg::flag_of] = alu_of;
  end

  // shifter cf is the last bit pushed out
  assign shamt    = operand_b[4:0];
  assign shl_wide = {{ex_types_pkg::data_w{1'b0}}, alu_a} << shamt;
  assign shr_wide = {alu_a, {ex_types_pkg::data_w{1'b0}}} >> shamt;

  always_comb begin
    if (uop.op == ex_ctrl_pkg::op_shl) begin
      shift_res = shl_wide[ex_types_pkg::data_w-1:0] & mask;
    end else begin
      shift_res = shr_wide[2*ex_types_pkg::data_w-1:ex_types_pkg::data_w];
    end
    shift_flags = flags_fwd;
    // zero count leaves flags alone
    if (shamt != '0) begin
      shift_flags[ex_ctrl_pkg::flag_cf] = (uop.op == ex_ctrl_pkg::op_shl) ?
                                          shl_wide[{1'b0, msb} + 6'd1] :
                                          shr_wide[ex_types_pkg::data_w-1];
      shift_flags[ex_ctrl_pkg::flag_zf] = (shift_res == '0);
      shift_flags[ex_ctrl_pkg::flag_sf] = shift_res[msb];
      shift_flags[ex_ctrl_pkg::flag_of] = 1'b0;
    end
  end

  // four independent 16-bit lanes with carries dropped
  always_comb begin
    ex_types_pkg::lane_t lane_sum;
    mm_sum = '0;
    for (int i = 0; i < ex_types_pkg::mm_lanes; i++) begin
      lane_sum = uop.mm_a[i*ex_types_pkg::lane_w +: ex_types_pkg::lane_w]
               + uop.mm_b[i*ex_types_pkg::lane_w +: ex_types_pkg::lane_w];
      mm_sum[i*ex_types_pkg::lane_w +: ex_types_pkg::lane_w] = lane_sum;
    end
  end

  always_comb begin
    raw.alu             = alu_res;
    raw.alu_flags       = alu_flags;
    raw.shift           = shift_res;
    raw.shift_flags     = shift_flags;
    raw.mm              = mm_sum;
    raw.count_minus_one = count - 32'd1;
    raw.sp_pop          = uop.a + 32'd4;
    // string pointer walks down when df is set
    raw.cmps_ptr        = flags_fwd[ex_ctrl_pkg::flag_df] ? uop.a - step : uop.a + step;
  end

endmodule

// ==== src/result_select_ex.sv ====
`timescale 1ns/10ps

module result_select_ex (
  input  ex_ctrl_pkg::ex_uop_t     uop,
  input  ex_ctrl_pkg::fu_raw_t     raw,
  output ex_ctrl_pkg::wb_bundle_t  wb
);

  logic                  is_shift;
  logic                  is_cmps;
  logic                  cmp_equal;
  ex_types_pkg::flags_t  flags_sel;
  ex_types_pkg::word_t   result_a_sel;

  assign is_shift = (uop.op == ex_ctrl_pkg::op_shl) || (uop.op == ex_ctrl_pkg::op_shr);
  assign is_cmps  = uop.is_cmps_first || uop.is_cmps_second;

  // alu is forced to a - c for cmpxchg
  assign cmp_equal = raw.alu_flags[ex_ctrl_pkg::flag_zf];

  assign flags_sel = is_shift ? raw.shift_flags : raw.alu_flags;

  always_comb begin
    if (uop.sp_pop) begin
      result_a_sel = raw.sp_pop;
    end else if (is_cmps) begin
      result_a_sel = raw.cmps_ptr;
    end else if (is_shift) begin
      result_a_sel = raw.shift;
    end else begin
      result_a_sel = raw.alu;
    end
  end

  always_comb begin
    wb.result_a     = result_a_sel;
    wb.result_b     = uop.b;
    wb.result_c     = uop.repne ? raw.count_minus_one : uop.c;
    wb.result_mm    = raw.mm;
    wb.flags        = flags_sel;
    wb.dr1          = uop.dr1;
    wb.dr2          = uop.dr2;
    wb.address      = uop.address;
    wb.ld_gpr1      = uop.ld_gpr1;
    wb.ld_gpr2      = uop.ld_gpr2;
    wb.ld_mm        = uop.ld_mm;
    wb.dcache_write = uop.dcache_write;
    wb.neip         = uop.neip;

    // equal stores to memory, unequal loads the old value into the accumulator
    if (uop.is_cmpxchg) begin
      if (cmp_equal) begin
        wb.ld_gpr1 = 1'b0;
      end else begin
        wb.ld_gpr1      = 1'b1;
        wb.result_a     = uop.a;
        wb.dcache_write = 1'b0;
      end
    end

    wb.repne_done = uop.repne &&
                    ((raw.count_minus_one == '0) || flags_sel[ex_ctrl_pkg::flag_zf]);
  end

endmodule

// ==== src/wb_latch_ex.sv ====
`timescale 1ns/10ps

module wb_latch_ex (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     in_valid,
  input  ex_ctrl_pkg::ex_uop_t     uop,
  input  ex_ctrl_pkg::wb_bundle_t  wb_in,
  input  logic                     wb_ready,
  output logic                     in_ready,
  output logic                     accept,
  output logic                     wb_valid,
  output ex_ctrl_pkg::wb_bundle_t  wb_out,
  output ex_ctrl_pkg::dep_t        dep_valid,
  output logic                     jmp_stall,
  output logic                     ld_flags_valid
);

  // room when empty or when the current entry drains this edge
  assign in_ready = !wb_valid || wb_ready;
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else if (accept) begin
      wb_valid <= 1'b1;
    end else if (wb_ready) begin
      wb_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wb_out <= wb_in;
    end
  end

  // final load bits after the cmpxchg decision
  always_comb begin
    dep_valid.gpr1         = in_valid && wb_in.ld_gpr1;
    dep_valid.gpr2         = in_valid && wb_in.ld_gpr2;
    dep_valid.mm           = in_valid && wb_in.ld_mm;
    dep_valid.dcache_write = in_valid && wb_in.dcache_write;
  end

  assign jmp_stall      = in_valid && uop.jmp_stall;
  assign ld_flags_valid = in_valid && uop.ld_flags;

  // held entry must not move while writeback stalls
  a_hold_on_stall: assert property (
    @(posedge clk) disable iff (reset)
    (wb_valid && !wb_ready) |=> (wb_valid && $stable(wb_out))
  );

endmodule

// ==== src/execute.sv ====
`timescale 1ns/10ps

module execute (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     in_valid,
  input  ex_ctrl_pkg::ex_uop_t     in_uop,
  input  ex_types_pkg::flags_t     flags_fwd,
  input  ex_types_pkg::count_t     count_fwd,
  input  logic                     wb_ready,
  output logic                     in_ready,
  output logic                     wb_valid,
  output ex_ctrl_pkg::wb_bundle_t  wb_out,
  output ex_ctrl_pkg::dep_t        dep_valid,
  output logic                     jmp_stall,
  output logic                     ld_flags_valid
);

  ex_types_pkg::word_t      operand_b;
  ex_types_pkg::count_t     count;
  ex_ctrl_pkg::fu_raw_t     raw;
  ex_ctrl_pkg::wb_bundle_t  wb_next;
  logic                     accept;

  operand_select_ex u_operand_select_ex (
    .clk       (clk),
    .reset     (reset),
    .uop       (in_uop),
    .count_fwd (count_fwd),
    .accept    (accept),
    .operand_b (operand_b),
    .count     (count)
  );

  functional_unit_ex u_functional_unit_ex (
    .uop       (in_uop),
    .operand_b (operand_b),
    .count     (count),
    .flags_fwd (flags_fwd),
    .raw       (raw)
  );

  result_select_ex u_result_select_ex (
    .uop (in_uop),
    .raw (raw),
    .wb  (wb_next)
  );

  wb_latch_ex u_wb_latch_ex (
    .clk            (clk),
    .reset          (reset),
    .in_valid       (in_valid),
    .uop            (in_uop),
    .wb_in          (wb_next),
    .wb_ready       (wb_ready),
    .in_ready       (in_ready),
    .accept         (accept),
    .wb_valid       (wb_valid),
    .wb_out         (wb_out),
    .dep_valid      (dep_valid),
    .jmp_stall      (jmp_stall),
    .ld_flags_valid (ld_flags_valid)
  );

endmodule

// ==== test/tb_execute_ref.svh ====
`ifndef TB_EXECUTE_REF_SVH
`define TB_EXECUTE_REF_SVH

// expected writeback for one micro-op given the loop count the stage should use
function automatic ex_ctrl_pkg::wb_bundle_t ref_execute(
  input ex_ctrl_pkg::ex_uop_t  uop,
  input ex_types_pkg::flags_t  flags_fwd,
  input ex_types_pkg::count_t  count
);
  ex_ctrl_pkg::wb_bundle_t  wb;
  ex_types_pkg::word_t      mask;
  ex_types_pkg::word_t      step;
  ex_types_pkg::word_t      x;
  ex_types_pkg::word_t      y;
  ex_types_pkg::word_t      r;
  int                       bits;
  int                       sh;
  logic [4:0]               top;
  logic                     carry;
  logic                     ovf;
  logic                     shifting;

  case (uop.size)
    ex_ctrl_pkg::size_byte: bits = 8;
    ex_ctrl_pkg::size_word: bits = 16;
    default:                bits = 32;
  endcase
  mask = (bits == 32) ? 32'hffff_ffff : ((32'd1 << bits) - 32'd1);
  step = ex_types_pkg::word_t'(bits / 8);
  top = 5'(bits - 1);
  x = uop.a & mask;
  // cmpxchg compares against the accumulator value in c
  y = (uop.is_cmpxchg ? uop.c : uop.b) & mask;
  sh = int'(uop.b[4:0]);
  shifting = (uop.op == ex_ctrl_pkg::op_shl) || (uop.op == ex_ctrl_pkg::op_shr);
  carry = 1'b0;
  ovf = 1'b0;
  wb = '0;
  wb.flags = flags_fwd;

  if (shifting) begin
    if (uop.op == ex_ctrl_pkg::op_shl) begin
      r = (x << sh) & mask;
      if (sh != 0 && sh <= bits) begin
        carry = x[5'(bits - sh)];
      end
    end else begin
      r = x >> sh;
      if (sh != 0) begin
        carry = x[5'(sh - 1)];
      end
    end
    // flags pass through on a zero shift count
    if (sh != 0) begin
      wb.flags[ex_ctrl_pkg::flag_cf] = carry;
      wb.flags[ex_ctrl_pkg::flag_zf] = (r == '0);
      wb.flags[ex_ctrl_pkg::flag_sf] = r[top];
      wb.flags[ex_ctrl_pkg::flag_of] = 1'b0;
    end
  end else begin
    if (uop.is_cmpxchg || uop.op == ex_ctrl_pkg::op_sub) begin
      r = (x - y) & mask;
      carry = x < y;
      ovf = (x[top] != y[top]) && (r[top] != x[top]);
    end else if (uop.op == ex_ctrl_pkg::op_add) begin
      r = (x + y) & mask;
      carry = ({1'b0, x} + {1'b0, y}) > {1'b0, mask};
      ovf = (x[top] == y[top]) && (r[top] != x[top]);
    end else if (uop.op == ex_ctrl_pkg::op_and) begin
      r = x & y;
    end else if (uop.op == ex_ctrl_pkg::op_or) begin
      r = x | y;
    end else if (uop.op == ex_ctrl_pkg::op_xor) begin
      r = x ^ y;
    end else begin
      r = y;
    end
    wb.flags[ex_ctrl_pkg::flag_cf] = carry;
    wb.flags[ex_ctrl_pkg::flag_zf] = (r == '0);
    wb.flags[ex_ctrl_pkg::flag_sf] = r[top];
    wb.flags[ex_ctrl_pkg::flag_of] = ovf;
  end

  if (uop.sp_pop) begin
    wb.result_a = uop.a + 32'd4;
  end else if (uop.is_cmps_first || uop.is_cmps_second) begin
    // string pointer moves down when df is set
    wb.result_a = flags_fwd[ex_ctrl_pkg::flag_df] ? uop.a - step : uop.a + step;
  end else begin
    wb.result_a = r;
  end
  wb.result_b = uop.b;
  wb.result_c = uop.repne ? count - 32'd1 : uop.c;
  for (int i = 0; i < 4; i++) begin
    wb.result_mm[16*i +: 16] = uop.mm_a[16*i +: 16] + uop.mm_b[16*i +: 16];
  end
  wb.dr1 = uop.dr1;
  wb.dr2 = uop.dr2;
  wb.address = uop.address;
  wb.ld_gpr1 = uop.ld_gpr1;
  wb.ld_gpr2 = uop.ld_gpr2;
  wb.ld_mm = uop.ld_mm;
  wb.dcache_write = uop.dcache_write;
  wb.neip = uop.neip;

  // equal operands store, unequal ones reload the accumulator
  if (uop.is_cmpxchg) begin
    if (x == y) begin
      wb.ld_gpr1 = 1'b0;
    end else begin
      wb.ld_gpr1 = 1'b1;
      wb.result_a = uop.a;
      wb.dcache_write = 1'b0;
    end
  end
  wb.repne_done = uop.repne &&
                  (((count - 32'd1) == '0) || wb.flags[ex_ctrl_pkg::flag_zf]);
  return wb;
endfunction

`endif

// ==== test/tb_execute.sv ====
`timescale 1ns/10ps

module tb_execute;

  localparam int unsigned n_uops = 300;
  localparam int unsigned cycle_limit = 2 * n_uops + 50;

  logic                     clk;
  logic                     reset;
  logic                     in_valid;
  ex_ctrl_pkg::ex_uop_t     in_uop;
  ex_types_pkg::flags_t     flags_fwd;
  ex_types_pkg::count_t     count_fwd;
  logic                     wb_ready;
  logic                     in_ready;
  logic                     wb_valid;
  ex_ctrl_pkg::wb_bundle_t  wb_out;
  ex_ctrl_pkg::dep_t        dep_valid;
  logic                     jmp_stall;
  logic                     ld_flags_valid;

  ex_types_pkg::word_t      rng_state;
  ex_types_pkg::word_t      r;
  ex_types_pkg::count_t     run_count;
  int unsigned              repne_left;
  int unsigned              issued;

  ex_ctrl_pkg::wb_bundle_t  expected_q[$];
  ex_ctrl_pkg::wb_bundle_t  exp_now;
  ex_ctrl_pkg::wb_bundle_t  exp_head;
  ex_ctrl_pkg::dep_t        exp_dep;
  ex_types_pkg::count_t     model_count;
  ex_types_pkg::count_t     cnt_now;
  logic                     model_active;
  logic                     latch_full;
  logic                     accept_seen;
  logic                     done;
  int unsigned              popped;
  int unsigned              cycle_count;

  `include "tb_execute_ref.svh"

  execute dut0 (
    .clk            (clk),
    .reset          (reset),
    .in_valid       (in_valid),
    .in_uop         (in_uop),
    .flags_fwd      (flags_fwd),
    .count_fwd      (count_fwd),
    .wb_ready       (wb_ready),
    .in_ready       (in_ready),
    .wb_valid       (wb_valid),
    .wb_out         (wb_out),
    .dep_valid      (dep_valid),
    .jmp_stall      (jmp_stall),
    .ld_flags_valid (ld_flags_valid)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(input string what, input ex_types_pkg::word_t got,
                            input ex_types_pkg::word_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_mm(input string what, input ex_types_pkg::mm_t got,
                          input ex_types_pkg::mm_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_dep(input string what, input ex_ctrl_pkg::dep_t got,
                           input ex_ctrl_pkg::dep_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bundle(input ex_ctrl_pkg::wb_bundle_t got,
                              input ex_ctrl_pkg::wb_bundle_t exp);
    check_word("result_a", got.result_a, exp.result_a);
    check_word("result_b", got.result_b, exp.result_b);
    check_word("result_c", got.result_c, exp.result_c);
    check_mm("result_mm", got.result_mm, exp.result_mm);
    check_word("flags", got.flags, exp.flags);
    check_word("address", got.address, exp.address);
    check_word("neip", got.neip, exp.neip);
    // dr1, dr2, load bits and repne_done
    if (got !== exp) begin
      $display("Mismatch at %0t: control fields %b, expected %b", $time,
               {got.dr1, got.dr2, got.ld_gpr1, got.ld_gpr2, got.ld_mm,
                got.dcache_write, got.repne_done},
               {exp.dr1, exp.dr2, exp.ld_gpr1, exp.ld_gpr2, exp.ld_mm,
                exp.dcache_write, exp.repne_done});
      abort_run();
    end
  endtask

  function automatic ex_types_pkg::word_t xorshift32(input ex_types_pkg::word_t x);
    ex_types_pkg::word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic ex_types_pkg::word_t next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic ex_ctrl_pkg::ex_uop_t make_uop();
    ex_ctrl_pkg::ex_uop_t  u;
    ex_types_pkg::word_t   pick;
    logic [1:0]            sel;

    pick = next_rand();
    sel = (pick[4:3] == 2'd3) ? 2'd2 : pick[4:3];
    u = '0;
    u.op = ex_ctrl_pkg::alu_op_e'(pick[2:0]);
    u.size = ex_ctrl_pkg::datasize_e'(sel);
    u.ld_gpr1 = pick[5];
    u.ld_gpr2 = pick[6];
    u.ld_mm = pick[7];
    u.dcache_write = pick[8];
    u.jmp_stall = pick[9];
    u.ld_flags = pick[10];
    u.dr1 = pick[13:11];
    u.dr2 = pick[16:14];
    u.a = next_rand();
    u.b = next_rand();
    u.c = next_rand();
    u.mm_a = {next_rand(), next_rand()};
    u.mm_b = {next_rand(), next_rand()};
    u.address = next_rand();
    u.neip = next_rand();
    // now and then start a repne cmps run
    if (repne_left == 0 && pick[31:29] == 3'd0) begin
      repne_left = pick[24:22] + 1;
      run_count = {29'd0, pick[21:19]} + 32'd1;
    end
    if (repne_left != 0) begin
      repne_left = repne_left - 1;
      u.op = ex_ctrl_pkg::op_sub;
      u.repne = 1'b1;
      u.is_cmps_first = pick[25];
      u.is_cmps_second = !pick[25];
      u.c = run_count;
      // a match ends the loop early
      if (pick[28:26] == 3'd0) begin
        u.b = u.a;
      end
    end else if (pick[31:29] == 3'd1) begin
      u.op = ex_ctrl_pkg::op_sub;
      u.is_cmpxchg = 1'b1;
      if (pick[25]) begin
        u.c = u.a;
      end
    end else if (pick[31:29] == 3'd2) begin
      u.sp_pop = 1'b1;
    end
    return u;
  endfunction

  initial begin
    reset = 1'b1;
    in_valid = 1'b0;
    in_uop = '0;
    flags_fwd = '0;
    count_fwd = '0;
    wb_ready = 1'b0;
    rng_state = 32'd79875;
    repne_left = 0;
    run_count = '0;
    issued = 0;
    repeat (4) @(posedge clk);
    #10;
    reset = 1'b0;
    @(negedge clk);
    check_bit("wb_valid after reset", wb_valid, 1'b0);
    while (!done) begin
      @(posedge clk);
      #10;
      if (accept_seen) begin
        in_valid = 1'b0;
      end
      r = next_rand();
      // hold each uop until it is taken
      if (!in_valid && issued < n_uops && r[2:0] != 3'd0) begin
        in_uop = make_uop();
        flags_fwd = next_rand();
        count_fwd = next_rand();
        in_valid = 1'b1;
        issued = issued + 1;
      end
      // writeback stalls about one cycle in four
      wb_ready = (r[4:3] != 2'd0);
    end
    if (expected_q.size() == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("%0d accepted micro-ops never reached writeback", expected_q.size());
      abort_run();
    end
  end

  // scoreboard and per cycle output checks
  always @(negedge clk) begin
    if (reset) begin
      model_active = 1'b0;
      model_count = '0;
      latch_full = 1'b0;
      accept_seen = 1'b0;
      done = 1'b0;
      popped = 0;
    end else begin
      check_bit("wb_valid", wb_valid, latch_full);
      check_bit("in_ready", in_ready, !latch_full || wb_ready);
      if (wb_valid && wb_ready) begin
        if (expected_q.size() == 0) begin
          $display("writeback handshake at %0t with no accepted micro-op outstanding", $time);
          abort_run();
        end else begin
          exp_head = expected_q.pop_front();
          check_bundle(wb_out, exp_head);
          popped = popped + 1;
          if (popped == n_uops) begin
            done = 1'b1;
          end
        end
      end
      accept_seen = in_valid && in_ready;
      if (in_valid) begin
        if (in_uop.repne && model_active) begin
          cnt_now = model_count;
        end else if (in_uop.repne) begin
          cnt_now = in_uop.c;
        end else begin
          cnt_now = count_fwd;
        end
        exp_now = ref_execute(in_uop, flags_fwd, cnt_now);
        exp_dep.gpr1 = exp_now.ld_gpr1;
        exp_dep.gpr2 = exp_now.ld_gpr2;
        exp_dep.mm = exp_now.ld_mm;
        exp_dep.dcache_write = exp_now.dcache_write;
        check_dep("dep_valid", dep_valid, exp_dep);
        check_bit("jmp_stall", jmp_stall, in_uop.jmp_stall);
        check_bit("ld_flags_valid", ld_flags_valid, in_uop.ld_flags);
        if (accept_seen) begin
          expected_q.push_back(exp_now);
          if (in_uop.repne) begin
            model_active = cnt_now > 32'd1;
            model_count = (cnt_now == '0) ? '0 : cnt_now - 32'd1;
          end else begin
            model_active = 1'b0;
            model_count = '0;
          end
        end
      end else begin
        check_dep("idle dep_valid", dep_valid, '0);
        check_bit("idle jmp_stall", jmp_stall, 1'b0);
        check_bit("idle ld_flags_valid", ld_flags_valid, 1'b0);
      end
      // latch fills on accept and empties when writeback drains it
      if (accept_seen) begin
        latch_full = 1'b1;
      end else if (wb_ready) begin
        latch_full = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      cycle_count <= 0;
    end else if (cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles, %0d of %0d results checked",
               cycle_count, popped, n_uops);
      abort_run();
    end else begin
      cycle_count <= cycle_count + 1;
    end
  end

endmodule

// ==== project.f ====
+incdir+test
src/ex_types_pkg.sv
src/ex_ctrl_pkg.sv
src/operand_select_ex.sv
src/functional_unit_ex.sv
src/result_select_ex.sv
src/wb_latch_ex.sv
src/execute.sv
test/tb_execute.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_execute \
  -f project.f \
  -Mdir obj_dir \
  -o tb_execute
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build returned status $status"
  exit $status
fi

./obj_dir/tb_execute
status=$?
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit $status
fi

exit 0
